// ==== logic/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

  // default data width, each module carries its own XLEN parameter
  localparam int XLEN_DEFAULT = 32;

  // alu operations, encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_SUB    = 4'b1000,
    ALU_SLT    = 4'b0010,
    ALU_SLTU   = 4'b0011,
    ALU_AND    = 4'b0111,
    ALU_OR     = 4'b0110,
    ALU_XOR    = 4'b0100,
    ALU_SLL    = 4'b0001,
    ALU_SRL    = 4'b0101,
    ALU_SRA    = 4'b1101,
    // lui only, not a funct3 code
    ALU_PASS_B = 4'b1111
  } alu_op_e;

  // m extension ops, encoded as funct3
  typedef enum logic [2:0] {
    MD_MUL    = 3'b000,
    MD_MULH   = 3'b001,
    MD_MULHSU = 3'b010,
    MD_MULHU  = 3'b011,
    MD_DIV    = 3'b100,
    MD_DIVU   = 3'b101,
    MD_REM    = 3'b110,
    MD_REMU   = 3'b111
  } md_op_e;

  // branch condition, none for non-branch ops
  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } br_cond_e;

  // major opcodes handled by the stage
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_BRANCH = 7'b1100011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcode_e;

  typedef struct packed {
    logic [31:0]             instr;
    logic [XLEN_DEFAULT-1:0] pc;
    logic [XLEN_DEFAULT-1:0] rs1_val;
    logic [XLEN_DEFAULT-1:0] rs2_val;
  } issue_t;

  typedef struct packed {
    logic                    is_md;
    alu_op_e                 alu_op;
    md_op_e                  md_op;
    logic [XLEN_DEFAULT-1:0] op_a;
    logic [XLEN_DEFAULT-1:0] op_b;
    logic [4:0]              rd;
    br_cond_e                br_cond;
    logic [XLEN_DEFAULT-1:0] br_target;
  } uop_t;

  typedef struct packed {
    logic                    valid;
    logic [4:0]              rd;
    logic [XLEN_DEFAULT-1:0] value;
    logic                    br_taken;
    logic [XLEN_DEFAULT-1:0] br_target;
  } retire_t;

endpackage

`default_nettype wire

// ==== logic/exec_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_decoder import exec_pkg::*; #(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire         flush_i,
  input  wire         issue_valid_i,
  input  wire issue_t issue_i,
  input  wire         md_busy_i,
  output logic        issue_ready_o,
  output logic        uop_valid_o,
  output uop_t        uop_o
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic            accept;
  uop_t            uop_d;

  // instruction fields
  assign opcode = opcode_e'(issue_i.instr[6:0]);
  assign funct3 = issue_i.instr[14:12];
  assign funct7 = issue_i.instr[31:25];

  // sign-extended immediates
  assign imm_i = {{(XLEN-12){issue_i.instr[31]}}, issue_i.instr[31:20]};
  assign imm_b = {{(XLEN-13){issue_i.instr[31]}}, issue_i.instr[31], issue_i.instr[7],
                  issue_i.instr[30:25], issue_i.instr[11:8], 1'b0};
  // upper immediate, low bits zero
  assign imm_u = {issue_i.instr[31:12], {(XLEN-20){1'b0}}};

  always_comb begin
    // defaults, register form with rd from the word
    uop_d         = '0;
    uop_d.alu_op  = ALU_ADD;
    uop_d.md_op   = MD_MUL;
    uop_d.br_cond = BR_NONE;
    uop_d.op_a    = issue_i.rs1_val;
    uop_d.op_b    = issue_i.rs2_val;
    uop_d.rd      = issue_i.instr[11:7];
    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b0000001) begin
          // m extension, funct3 is the op code
          uop_d.is_md = 1'b1;
          uop_d.md_op = md_op_e'(funct3);
        end else if (funct3 == 3'b000 || funct3 == 3'b101) begin
          // funct7[5] picks sub and sra
          uop_d.alu_op = alu_op_e'({funct7[5], funct3});
        end else begin
          uop_d.alu_op = alu_op_e'({1'b0, funct3});
        end
      end
      OPC_OP_IMM: begin
        uop_d.op_b = imm_i;
        // no subi, only srai uses funct7[5]
        if (funct3 == 3'b101) begin
          uop_d.alu_op = alu_op_e'({funct7[5], funct3});
        end else begin
          uop_d.alu_op = alu_op_e'({1'b0, funct3});
        end
      end
      OPC_BRANCH: begin
        // sub sets the compare flags
        uop_d.alu_op    = ALU_SUB;
        uop_d.rd        = 5'd0;
        uop_d.br_target = issue_i.pc + imm_b;
        case (funct3)
          3'b000:  uop_d.br_cond = BR_EQ;
          3'b001:  uop_d.br_cond = BR_NE;
          3'b100:  uop_d.br_cond = BR_LT;
          3'b101:  uop_d.br_cond = BR_GE;
          3'b110:  uop_d.br_cond = BR_LTU;
          3'b111:  uop_d.br_cond = BR_GEU;
          // reserved funct3, never taken
          default: uop_d.br_cond = BR_NONE;
        endcase
      end
      OPC_LUI: begin
        uop_d.alu_op = ALU_PASS_B;
        uop_d.op_b   = imm_u;
      end
      OPC_AUIPC: begin
        uop_d.op_a = issue_i.pc;
        uop_d.op_b = imm_u;
      end
      default: begin
        // unsupported opcode retires as a nop
        uop_d.rd   = 5'd0;
        uop_d.op_a = '0;
        uop_d.op_b = '0;
      end
    endcase
  end

  // stall on a running muldiv and on the cycle a muldiv op is handed over
  assign issue_ready_o = !flush_i && !md_busy_i && !(uop_valid_o && uop_o.is_md);
  assign accept        = issue_valid_i && issue_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      uop_valid_o <= 1'b0;
    end else begin
      uop_valid_o <= accept;
    end
  end

  // micro-op payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      uop_o <= uop_d;
    end
  end

  // upstream holds a stalled request
  a_issue_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    issue_valid_i && !issue_ready_o |=> issue_valid_i && $stable(issue_i));

endmodule

`default_nettype wire

// ==== logic/rv32im_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32im_alu import exec_pkg::*; #(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  wire              clk_i,
  input  wire              rst_i,
  input  wire              flush_i,
  input  wire              uop_valid_i,
  input  wire uop_t        uop_i,
  output logic             alu_valid_o,
  output logic [XLEN-1:0]  result_o,
  output logic             equal_o,
  output logic             less_o,
  output logic             less_signed_o
);

  logic [XLEN-1:0]        a;
  logic [XLEN-1:0]        b;
  logic signed [XLEN-1:0] a_s;
  logic signed [XLEN-1:0] b_s;
  logic                   eq;
  logic                   lt;
  logic                   lt_s;
  logic                   load;

  assign a    = uop_i.op_a;
  assign b    = uop_i.op_b;
  assign a_s  = uop_i.op_a;
  assign b_s  = uop_i.op_b;
  // compares shared by slt and branches
  assign eq   = a == b;
  assign lt   = a < b;
  assign lt_s = a_s < b_s;

  // muldiv ops bypass the alu
  assign load = uop_valid_i && !uop_i.is_md;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      alu_valid_o <= 1'b0;
    end else begin
      alu_valid_o <= load;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      case (uop_i.alu_op)
        ALU_ADD:    result_o <= a + b;
        ALU_SUB:    result_o <= a - b;
        ALU_SLT:    result_o <= {{(XLEN-1){1'b0}}, lt_s};
        ALU_SLTU:   result_o <= {{(XLEN-1){1'b0}}, lt};
        ALU_AND:    result_o <= a & b;
        ALU_OR:     result_o <= a | b;
        ALU_XOR:    result_o <= a ^ b;
        // shift amount from the low 5 bits
        ALU_SLL:    result_o <= a << b[4:0];
        ALU_SRL:    result_o <= a >> b[4:0];
        ALU_SRA:    result_o <= a_s >>> b[4:0];
        ALU_PASS_B: result_o <= b;
        default:    result_o <= '0;
      endcase
    end
  end

  // flags cleared on flush
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      equal_o       <= 1'b0;
      less_o        <= 1'b0;
      less_signed_o <= 1'b0;
    end else if (load) begin
      equal_o       <= eq;
      less_o        <= lt;
      less_signed_o <= lt_s;
    end
  end

endmodule

`default_nettype wire

// ==== logic/muldiv_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit import exec_pkg::*; #(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  wire              clk_i,
  input  wire              rst_i,
  input  wire              flush_i,
  input  wire              uop_valid_i,
  input  wire uop_t        uop_i,
  output logic             busy_o,
  output logic             done_o,
  output logic [4:0]       rd_o,
  output logic [XLEN-1:0]  result_o
);

  localparam int CNT_W = $clog2(XLEN);

  typedef enum logic [1:0] {IDLE, MUL, DIV, DONE} state_e;

  state_e            state;
  logic [CNT_W-1:0]  count;
  md_op_e            op_q;
  // hi/lo hold the product or the remainder and quotient
  logic [XLEN-1:0]   hi;
  logic [XLEN-1:0]   lo;
  // multiplicand or divisor magnitude
  logic [XLEN-1:0]   opnd;
  logic              neg_q;
  logic              neg_r;
  logic              start;
  logic              a_neg;
  logic              b_neg;
  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;
  logic [XLEN:0]     add_sum;
  logic [XLEN:0]     rem_shift;
  logic [XLEN:0]     rem_diff;
  logic [2*XLEN-1:0] product;
  logic              last;
  logic              div_zero;

  assign start = uop_valid_i && uop_i.is_md;

  // operand signs by op
  assign a_neg = uop_i.op_a[XLEN-1] && (uop_i.md_op inside {MD_MULH, MD_MULHSU, MD_DIV, MD_REM});
  assign b_neg = uop_i.op_b[XLEN-1] && (uop_i.md_op inside {MD_MULH, MD_DIV, MD_REM});
  assign a_mag = a_neg ? -uop_i.op_a : uop_i.op_a;
  assign b_mag = b_neg ? -uop_i.op_b : uop_i.op_b;

  // shift-and-add step shifts multiplier bits out of lo from the bottom
  assign add_sum   = {1'b0, hi} + (lo[0] ? {1'b0, opnd} : '0);
  // restoring divide step shifts the dividend msb into the remainder
  assign rem_shift = {hi, lo[XLEN-1]};
  assign rem_diff  = rem_shift - {1'b0, opnd};

  assign last     = count == CNT_W'(XLEN - 1);
  // checked on the first div cycle only
  assign div_zero = (count == '0) && (opnd == '0);

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          count <= '0;
          if (start) begin
            // md_op[2] marks the divide ops
            state <= uop_i.md_op[2] ? DIV : MUL;
          end
        end
        MUL: begin
          count <= count + CNT_W'(1);
          if (last) state <= DONE;
        end
        DIV: begin
          count <= count + CNT_W'(1);
          if (last || div_zero) state <= DONE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    case (state)
      IDLE: begin
        if (start) begin
          op_q  <= uop_i.md_op;
          rd_o  <= uop_i.rd;
          hi    <= '0;
          neg_q <= a_neg ^ b_neg;
          neg_r <= a_neg;
          if (uop_i.md_op[2]) begin
            lo   <= a_mag;
            opnd <= b_mag;
          end else begin
            lo   <= b_mag;
            opnd <= a_mag;
          end
        end
      end
      MUL: begin
        hi <= add_sum[XLEN:1];
        lo <= {add_sum[0], lo[XLEN-1:1]};
      end
      DIV: begin
        if (div_zero) begin
          // all-ones quotient and dividend as remainder
          hi    <= lo;
          lo    <= '1;
          neg_q <= 1'b0;
        end else if (!rem_diff[XLEN]) begin
          hi <= rem_diff[XLEN-1:0];
          lo <= {lo[XLEN-2:0], 1'b1};
        end else begin
          hi <= rem_shift[XLEN-1:0];
          lo <= {lo[XLEN-2:0], 1'b0};
        end
      end
      // done holds the result
      default: begin
      end
    endcase
  end

  // sign fix on the magnitude product
  assign product = neg_q ? -{hi, lo} : {hi, lo};

  always_comb begin
    case (op_q)
      MD_MUL:                       result_o = product[XLEN-1:0];
      MD_MULH, MD_MULHSU, MD_MULHU: result_o = product[2*XLEN-1:XLEN];
      MD_DIV, MD_DIVU:              result_o = neg_q ? -lo : lo;
      // remainder takes the dividend sign
      default:                      result_o = neg_r ? -hi : hi;
    endcase
  end

  // busy drops in done so issue reopens a cycle early
  assign busy_o = (state == MUL) || (state == DIV);
  assign done_o = state == DONE;

  // decoder never hands over a muldiv op unless the unit is idle
  a_start_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    start |-> state == IDLE);

endmodule

`default_nettype wire

// ==== logic/retire_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module retire_select import exec_pkg::*; #(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  wire              clk_i,
  input  wire              rst_i,
  input  wire              flush_i,
  input  wire              uop_valid_i,
  input  wire uop_t        uop_i,
  input  wire              alu_valid_i,
  input  wire [XLEN-1:0]   alu_result_i,
  input  wire              equal_i,
  input  wire              less_i,
  input  wire              less_signed_i,
  input  wire              md_done_i,
  input  wire [4:0]        md_rd_i,
  input  wire [XLEN-1:0]   md_result_i,
  output retire_t          retire_o
);

  logic            load;
  logic [4:0]      rd_q;
  br_cond_e        br_cond_q;
  logic [XLEN-1:0] br_target_q;
  logic            taken;

  // same load as the alu so the fields line up with its output
  assign load = uop_valid_i && !uop_i.is_md;

  always_ff @(posedge clk_i) begin
    if (load) begin
      rd_q        <= uop_i.rd;
      br_cond_q   <= uop_i.br_cond;
      br_target_q <= uop_i.br_target;
    end
  end

  // branch outcome from the alu flags
  always_comb begin
    case (br_cond_q)
      BR_EQ:   taken = equal_i;
      BR_NE:   taken = !equal_i;
      BR_LT:   taken = less_signed_i;
      BR_GE:   taken = !less_signed_i;
      BR_LTU:  taken = less_i;
      BR_GEU:  taken = !less_i;
      default: taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      retire_o.valid <= 1'b0;
    end else begin
      retire_o.valid <= alu_valid_i || md_done_i;
    end
    if (md_done_i) begin
      retire_o.rd        <= md_rd_i;
      retire_o.value     <= md_result_i;
      retire_o.br_taken  <= 1'b0;
      retire_o.br_target <= '0;
    end else begin
      retire_o.rd        <= rd_q;
      // branches write no value
      retire_o.value     <= (br_cond_q == BR_NONE) ? alu_result_i : '0;
      retire_o.br_taken  <= taken;
      retire_o.br_target <= br_target_q;
    end
  end

  // issue stall keeps the two sources apart
  a_one_source: assert property (@(posedge clk_i) disable iff (rst_i)
    !(alu_valid_i && md_done_i));

endmodule

`default_nettype wire

// ==== logic/exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_top import exec_pkg::*; #(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire         flush_i,
  input  wire         issue_valid_i,
  input  wire issue_t issue_i,
  output logic        issue_ready_o,
  output retire_t     retire_o
);

  // decode to execute
  logic            uop_valid;
  uop_t            uop;
  logic            md_busy;
  // alu results
  logic            alu_valid;
  logic [XLEN-1:0] alu_result;
  logic            equal;
  logic            less;
  logic            less_signed;
  // muldiv results
  logic            md_done;
  logic [4:0]      md_rd;
  logic [XLEN-1:0] md_result;

  exec_decoder #(.XLEN(XLEN)) exec_decoder_inst (
    .clk_i(clk_i), .rst_i(rst_i), .flush_i(flush_i),
    .issue_valid_i(issue_valid_i), .issue_i(issue_i), .md_busy_i(md_busy),
    .issue_ready_o(issue_ready_o), .uop_valid_o(uop_valid), .uop_o(uop)
  );

  rv32im_alu #(.XLEN(XLEN)) rv32im_alu_inst (
    .clk_i(clk_i), .rst_i(rst_i), .flush_i(flush_i),
    .uop_valid_i(uop_valid), .uop_i(uop),
    .alu_valid_o(alu_valid), .result_o(alu_result),
    .equal_o(equal), .less_o(less), .less_signed_o(less_signed)
  );

  muldiv_unit #(.XLEN(XLEN)) muldiv_unit_inst (
    .clk_i(clk_i), .rst_i(rst_i), .flush_i(flush_i),
    .uop_valid_i(uop_valid), .uop_i(uop),
    .busy_o(md_busy), .done_o(md_done), .rd_o(md_rd), .result_o(md_result)
  );

  retire_select #(.XLEN(XLEN)) retire_select_inst (
    .clk_i(clk_i), .rst_i(rst_i), .flush_i(flush_i),
    .uop_valid_i(uop_valid), .uop_i(uop),
    .alu_valid_i(alu_valid), .alu_result_i(alu_result),
    .equal_i(equal), .less_i(less), .less_signed_i(less_signed),
    .md_done_i(md_done), .md_rd_i(md_rd), .md_result_i(md_result),
    .retire_o(retire_o)
  );

endmodule

`default_nettype wire

// ==== dv/exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_tb import exec_pkg::*; ();

  localparam int TIMEOUT = 100;

  // stimulus and expected retire for one instruction
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [4:0]  rd;
    logic [31:0] value;
    logic        br_taken;
    logic [31:0] br_target;
  } test_entry_t;

  logic        clk_i;
  logic        rst_i;
  logic        flush_i;
  logic        issue_valid_i;
  issue_t      issue_i;
  logic        issue_ready_o;
  retire_t     retire_o;

  test_entry_t tests_q[$];
  integer      seed = 32'h47ebf73f;
  int          errors;
  int          tests_run;
  int          tests_failed;
  bit          timed_out;

  exec_top #(.XLEN(32)) exec_top_inst (
    .clk_i(clk_i), .rst_i(rst_i), .flush_i(flush_i),
    .issue_valid_i(issue_valid_i), .issue_i(issue_i),
    .issue_ready_o(issue_ready_o), .retire_o(retire_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // instruction encoders, rs1 = x1 and rs2 = x2 in the word
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {imm, 5'd1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  // rv32i integer ops, alt selects sub and sra
  function automatic logic [31:0] alu_calc(input logic alt, input logic [2:0] f3,
                                           input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] a_s;
    a_s = a;
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'd0, $signed(a) < $signed(b)};
      3'b011: return {31'd0, a < b};
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) return a_s >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // m extension with the riscv divide-by-zero and overflow results
  function automatic logic [31:0] md_calc(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [63:0]        sa;
    logic [63:0]        sb;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        p;
    logic signed [31:0] a_s;
    logic signed [31:0] b_s;
    logic signed [31:0] r_s;
    logic               ovf;
    sa  = {{32{a[31]}}, a};
    sb  = {{32{b[31]}}, b};
    ua  = {32'd0, a};
    ub  = {32'd0, b};
    a_s = a;
    b_s = b;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (f3)
      3'b000: begin
        p = ua * ub;
        return p[31:0];
      end
      3'b001: begin
        p = sa * sb;
        return p[63:32];
      end
      3'b010: begin
        p = sa * ub;
        return p[63:32];
      end
      3'b011: begin
        p = ua * ub;
        return p[63:32];
      end
      3'b100: begin
        if (b == '0) return '1;
        if (ovf) return a;
        r_s = a_s / b_s;
        return r_s;
      end
      3'b101: begin
        if (b == '0) return '1;
        return a / b;
      end
      3'b110: begin
        if (b == '0) return a;
        if (ovf) return '0;
        r_s = a_s % b_s;
        return r_s;
      end
      default: begin
        if (b == '0) return a;
        return a % b;
      end
    endcase
  endfunction

  // expected retire from the instruction word and operands
  function automatic test_entry_t ref_model(input logic [31:0] instr, input logic [31:0] pc,
                                            input logic [31:0] a, input logic [31:0] b);
    test_entry_t e;
    logic [2:0]  f3;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    e       = '0;
    e.instr = instr;
    e.pc    = pc;
    e.rs1   = a;
    e.rs2   = b;
    e.rd    = instr[11:7];
    f3      = instr[14:12];
    imm_i   = {{20{instr[31]}}, instr[31:20]};
    imm_b   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    case (instr[6:0])
      7'b0110011: begin
        if (instr[31:25] == 7'b0000001) e.value = md_calc(f3, a, b);
        else e.value = alu_calc(instr[30], f3, a, b);
      end
      // only srai uses bit 30 of the immediate
      7'b0010011: e.value = alu_calc(instr[30] && f3 == 3'b101, f3, a, imm_i);
      7'b1100011: begin
        e.rd        = '0;
        e.br_target = pc + imm_b;
        case (f3)
          3'b000:  e.br_taken = a == b;
          3'b001:  e.br_taken = a != b;
          3'b100:  e.br_taken = $signed(a) < $signed(b);
          3'b101:  e.br_taken = $signed(a) >= $signed(b);
          3'b110:  e.br_taken = a < b;
          3'b111:  e.br_taken = a >= b;
          default: e.br_taken = 1'b0;
        endcase
      end
      7'b0110111: e.value = {instr[31:12], 12'd0};
      7'b0010111: e.value = pc + {instr[31:12], 12'd0};
      // anything else is a nop
      default: e.rd = '0;
    endcase
    return e;
  endfunction

  task automatic add_test(input logic [31:0] instr, input logic [31:0] pc,
                          input logic [31:0] a, input logic [31:0] b);
    tests_q.push_back(ref_model(instr, pc, a, b));
  endtask

  task automatic fill_table();
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] imm;
    logic [2:0]  br_f3 [6];
    logic [31:0] br_a [5];
    logic [31:0] br_b [5];
    logic [31:0] md_a [6];
    logic [31:0] md_b [6];
    br_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    br_a  = '{32'd5, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'd0};
    br_b  = '{32'd5, 32'h7fff_ffff, 32'h8000_0000, 32'd1, 32'hffff_ffff};
    // includes divide by zero and the signed overflow pair
    md_a  = '{32'h1234_5678, 32'hffff_fff9, 32'd5, 32'd7, 32'h8000_0000, 32'd0};
    md_b  = '{32'h0000_9abc, 32'd3, 32'hffff_fffe, 32'd0, 32'hffff_ffff, 32'd0};
    md_a[5] = $random(seed);
    md_b[5] = $random(seed);
    // first pass fixed operands, then random
    for (int r = 0; r < 4; r++) begin
      a = $random(seed);
      b = $random(seed);
      if (r == 0) begin
        a = 32'h8000_0001;
        b = 32'hffff_fff3;
      end
      for (int f = 0; f < 8; f++) begin
        // shift immediates carry only a shamt
        imm = (f == 1 || f == 5) ? {7'h00, b[4:0]} : b[11:0];
        add_test(enc_r(7'h00, 3'(f), 5'(f + 1)), 32'h1000, a, b);
        add_test(enc_i(imm, 3'(f), 5'(f + 9)), 32'h1000, a, b);
      end
      add_test(enc_r(7'h20, 3'b000, 5'd17), 32'h1000, a, b);
      add_test(enc_r(7'h20, 3'b101, 5'd18), 32'h1000, a, b);
      add_test(enc_i({7'h20, b[4:0]}, 3'b101, 5'd19), 32'h1000, a, b);
    end
    add_test(enc_u(20'hdead5, 5'd3, 7'b0110111), 32'h1000, a, b);
    add_test(enc_u(20'hfffff, 5'd4, 7'b0010111), 32'h8000_0f00, a, b);
    // lw is outside the stage
    add_test(32'h0000_2083, 32'h1000, a, b);
    // forward and backward targets
    for (int p = 0; p < 5; p++) begin
      for (int c = 0; c < 6; c++) begin
        add_test(enc_b((p % 2 == 1) ? 13'h1f00 : 13'h0ffe, br_f3[c]),
                 32'h2000 + 32'(p * 16), br_a[p], br_b[p]);
      end
    end
    for (int p = 0; p < 6; p++) begin
      for (int f = 0; f < 8; f++) begin
        add_test(enc_r(7'h01, 3'(f), 5'(p + 24)), 32'h3000, md_a[p], md_b[p]);
      end
    end
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: mismatch", tests_run, name);
    end
  endtask

  // returns one cycle after the transfer edge
  task automatic issue_one(input test_entry_t t);
    int waited;
    issue_i       = '{instr: t.instr, pc: t.pc, rs1_val: t.rs1, rs2_val: t.rs2};
    issue_valid_i = 1'b1;
    waited        = 0;
    while (!issue_ready_o && waited < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (issue_ready_o) begin
      @(posedge clk_i);
      #1;
    end else begin
      $display("timeout waiting for issue_ready_o on instr %h", t.instr);
      errors++;
      timed_out = 1'b1;
    end
    issue_valid_i = 1'b0;
  endtask

  task automatic run_entry(input test_entry_t t);
    int  errs_before;
    int  lat;
    int  low;
    int  exp_lat;
    bit  md;
    errs_before = errors;
    md      = t.instr[6:0] == 7'b0110011 && t.instr[31:25] == 7'b0000001;
    // a zero divisor skips the iteration
    exp_lat = !md ? 2 : (t.instr[14] && t.rs2 == '0) ? 3 : 34;
    issue_one(t);
    if (timed_out) return;
    lat = 0;
    low = 0;
    while (!retire_o.valid && lat < TIMEOUT) begin
      if (!issue_ready_o) low++;
      @(posedge clk_i);
      #1;
      lat++;
    end
    if (!retire_o.valid) begin
      $display("timeout waiting for retire_o.valid on instr %h", t.instr);
      errors++;
      timed_out = 1'b1;
      return;
    end
    check_field("retire_o.rd", 32'(retire_o.rd), 32'(t.rd));
    check_field("retire_o.value", retire_o.value, t.value);
    check_field("retire_o.br_taken", 32'(retire_o.br_taken), 32'(t.br_taken));
    if (t.instr[6:0] == 7'b1100011) begin
      check_field("retire_o.br_target", retire_o.br_target, t.br_target);
    end
    assert (lat == exp_lat) else begin
      $display("retire came %0d cycles after issue, expected %0d", lat, exp_lat);
      errors++;
    end
    // muldiv holds issue until its last cycle
    assert (low == (md ? exp_lat - 1 : 0)) else begin
      $display("issue_ready_o was low for %0d cycles after issue", low);
      errors++;
    end
    finish_test($sformatf("instr %h", t.instr), errs_before);
  endtask

  // alu ops on consecutive cycles retire in order, one each
  task automatic run_burst();
    test_entry_t exp_q[$];
    int          errs_before;
    int          got;
    errs_before = errors;
    got = 0;
    for (int i = 0; i < 4; i++) begin
      exp_q.push_back(ref_model(enc_r(7'h00, 3'b000, 5'(i + 20)), 32'h3000,
                                32'(i * 3), 32'(100 + i)));
    end
    @(posedge clk_i);
    #1;
    for (int c = 0; c < 8; c++) begin
      if (retire_o.valid) begin
        assert (got < 4) else begin
          $display("extra retire during back-to-back issue");
          errors++;
        end
        if (got < 4) begin
          check_field("retire_o.rd", 32'(retire_o.rd), 32'(exp_q[got].rd));
          check_field("retire_o.value", retire_o.value, exp_q[got].value);
        end
        got++;
      end
      if (c < 4) begin
        assert (issue_ready_o) else begin
          $display("issue_ready_o dropped during back-to-back issue");
          errors++;
        end
        issue_i = '{instr: exp_q[c].instr, pc: exp_q[c].pc,
                    rs1_val: exp_q[c].rs1, rs2_val: exp_q[c].rs2};
      end
      issue_valid_i = (c < 4);
      @(posedge clk_i);
      #1;
    end
    check_field("retire count", 32'(got), 32'd4);
    finish_test("back-to-back alu", errs_before);
  endtask

  task automatic run_flush();
    test_entry_t t;
    int          errs_before;
    int          retires;
    errs_before = errors;
    retires = 0;
    @(posedge clk_i);
    #1;
    // two alu ops in flight when flush hits
    for (int c = 0; c < 12; c++) begin
      if (retire_o.valid) retires++;
      if (c < 2) begin
        assert (issue_ready_o) else begin
          $display("issue_ready_o low before flush");
          errors++;
        end
        t = ref_model(enc_r(7'h00, 3'b000, 5'(c + 1)), 32'h4000, 32'd1, 32'd2);
        issue_i = '{instr: t.instr, pc: t.pc, rs1_val: t.rs1, rs2_val: t.rs2};
      end
      issue_valid_i = (c < 2);
      flush_i       = (c == 2);
      @(posedge clk_i);
      #1;
    end
    // divide killed mid-iteration
    issue_one(ref_model(enc_r(7'h01, 3'b100, 5'd7), 32'h4000, 32'd100, 32'd7));
    if (timed_out) return;
    for (int c = 0; c < 45; c++) begin
      if (retire_o.valid) retires++;
      flush_i = (c == 10);
      @(posedge clk_i);
      #1;
    end
    flush_i = 1'b0;
    assert (retires == 0) else begin
      $display("%0d retires seen from flushed instructions", retires);
      errors++;
    end
    finish_test("flush", errs_before);
  endtask

  initial begin
    int errs_before;
    rst_i         = 1'b1;
    flush_i       = 1'b0;
    issue_valid_i = 1'b0;
    issue_i       = '0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    timed_out     = 1'b0;
    fill_table();
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    // idle state out of reset
    errs_before = errors;
    check_field("issue_ready_o", 32'(issue_ready_o), 32'd1);
    check_field("retire_o.valid", 32'(retire_o.valid), 32'd0);
    finish_test("reset", errs_before);
    for (int i = 0; i < tests_q.size() && !timed_out; i++) begin
      run_entry(tests_q[i]);
    end
    if (!timed_out) run_burst();
    if (!timed_out) run_flush();
    // first instruction after the flush
    if (!timed_out) begin
      run_entry(ref_model(enc_r(7'h00, 3'b111, 5'd30), 32'h5000, 32'hf0f0_1234,
                          32'h0ff0_ff00));
    end
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/exec_pkg.sv
logic/exec_decoder.sv
logic/rv32im_alu.sv
logic/muldiv_unit.sv
logic/retire_select.sv
logic/exec_top.sv
dv/exec_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module exec_tb -o exec_tb_sim
./obj_dir/exec_tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "^PASS: all tests$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
